// File: src.f
+incdir+.
simd_alu_pkg.sv
pipe_reg.sv
simd_alu_cfg.sv
simd_addsub.sv
simd_minmax.sv
simd_alu_core.sv
simd_alu_top.sv
simd_alu_checker.sv
tb_simd_alu.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_simd_alu -o tb_simd_alu
	./obj_dir/tb_simd_alu | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_simd_alu.sv
// SIMD ALU testbench with clock, reset, LFSR stimulus and back-pressure
`timescale 1ns/1ns
`default_nettype none

`include "simd_alu_consts.svh"

module tb_simd_alu;

  localparam int TIMEOUT_CYC = 200;

  logic                  clk_i;
  logic                  arst_n_i;
  logic                  cfg_we_i;
  simd_alu_pkg::alu_op_e cfg_op_i;
  simd_alu_pkg::vew_e    cfg_vew_i;
  logic                  sat_clr_i;
  logic                  in_valid_i;
  simd_alu_pkg::word_t   opa_i;
  simd_alu_pkg::word_t   opb_i;
  logic                  in_ready_o;
  logic                  out_valid_o;
  simd_alu_pkg::word_t   result_o;
  simd_alu_pkg::sat_t    vxsat_o;
  logic                  out_ready_i;
  logic                  vxsat_sticky_o;
  logic                  bp_en;
  logic [15:0]           lfsr_q;
  int                    timeout_cnt;
  int                    mismatch_cnt;
  int                    fault_cnt;
  int                    pending;

  simd_alu_top simd_alu_top_i (
    .clk_i, .arst_n_i, .cfg_we_i, .cfg_op_i, .cfg_vew_i, .sat_clr_i, .in_valid_i,
    .opa_i, .opb_i, .in_ready_o, .out_valid_o, .result_o, .vxsat_o, .out_ready_i,
    .vxsat_sticky_o
  );

  simd_alu_checker u_checker (
    .clk_i, .arst_n_i, .cfg_we_i, .cfg_op_i, .cfg_vew_i, .sat_clr_i, .in_valid_i,
    .opa_i, .opb_i, .in_ready_i (in_ready_o), .out_valid_i (out_valid_o),
    .result_i (result_o), .vxsat_i (vxsat_o), .out_ready_i,
    .vxsat_sticky_i (vxsat_sticky_o), .mismatch_cnt_o (mismatch_cnt),
    .fault_cnt_o (fault_cnt), .pending_o (pending)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);
      v = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic simd_alu_pkg::word_t lane_fill(input simd_alu_pkg::vew_e vew,
                                                    input logic [63:0] val);
    simd_alu_pkg::word_t word;
    int                  w;
    w    = 8 << vew;
    word = '0;
    for (int l = 0; l < `SIMD_DATA_W / w; l++) begin
      word = word | (val << (l * w));
    end
    return word;
  endfunction

  task automatic finish_run();
    $display("errors: mismatches=%0d faults=%0d timeouts=%0d", mismatch_cnt, fault_cnt,
             timeout_cnt);
    if (mismatch_cnt + fault_cnt + timeout_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // Pulses last one edge and ready toggles under back-pressure
  task automatic next_cycle();
    @(posedge clk_i);
    cfg_we_i    <= 1'b0;
    sat_clr_i   <= 1'b0;
    out_ready_i <= bp_en ? (rand_bits(2) != 64'd0) : 1'b1;
  endtask

  task automatic write_cfg(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vew);
    cfg_we_i  <= 1'b1;
    cfg_op_i  <= op;
    cfg_vew_i <= vew;
    next_cycle();
  endtask

  task automatic send_item(input simd_alu_pkg::word_t a, input simd_alu_pkg::word_t b);
    int   waited;
    logic taken;
    waited = 0;
    taken  = 1'b0;
    in_valid_i <= 1'b1;
    opa_i      <= a;
    opb_i      <= b;
    while (!taken && waited <= TIMEOUT_CYC) begin
      @(negedge clk_i);
      taken = in_ready_o;
      next_cycle();
      waited++;
    end
    if (!taken) begin
      $display("ERROR at %0t: in_ready_o stayed low for %0d cycles", $time, waited);
      timeout_cnt++;
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic drain();
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    while (!done && waited <= TIMEOUT_CYC) begin
      @(negedge clk_i);
      done = (pending == 0);
      next_cycle();
      waited++;
    end
    if (!done) begin
      $display("ERROR at %0t: %0d results never left the pipeline", $time, pending);
      timeout_cnt++;
    end
  endtask

  task automatic sweep_config(input simd_alu_pkg::alu_op_e op, input simd_alu_pkg::vew_e vew);
    int                  w;
    logic [63:0]         smin;
    simd_alu_pkg::word_t a;
    simd_alu_pkg::word_t b;
    w    = 8 << vew;
    smin = 64'd1 << (w - 1);
    write_cfg(op, vew);
    // Lane corners of all ones plus one, zero minus one and the signed limits
    send_item('1, lane_fill(vew, 64'd1));
    send_item(lane_fill(vew, 64'd1), '0);
    send_item(lane_fill(vew, smin - 64'd1), lane_fill(vew, 64'd1));
    send_item(lane_fill(vew, 64'd1), lane_fill(vew, smin));
    // Operands differing only in the sign bit
    send_item(lane_fill(vew, smin | 64'd3), lane_fill(vew, 64'd3));
    for (int i = 0; i < 10; i++) begin
      a = rand_bits(64);
      b = rand_bits(64);
      send_item(a, b);
    end
    drain();
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    arst_n_i    = 1'b0;
    cfg_we_i    = 1'b0;
    cfg_op_i    = simd_alu_pkg::OP_ADD;
    cfg_vew_i   = simd_alu_pkg::EW8;
    sat_clr_i   = 1'b0;
    in_valid_i  = 1'b0;
    opa_i       = '0;
    opb_i       = '0;
    out_ready_i = 1'b1;
    bp_en       = 1'b0;
    lfsr_q      = 16'd22916;
    timeout_cnt = 0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    next_cycle();
    bp_en = 1'b1;
    for (int op = 0; op < `SIMD_OP_CNT; op++) begin
      for (int v = 0; v < 4; v++) begin
        sweep_config(simd_alu_pkg::alu_op_e'(op[3:0]), simd_alu_pkg::vew_e'(v[1:0]));
      end
    end
    // Config changes around items already accepted
    write_cfg(simd_alu_pkg::OP_ADD, simd_alu_pkg::EW16);
    send_item(64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210);
    cfg_we_i  <= 1'b1;
    cfg_op_i  <= simd_alu_pkg::OP_XOR;
    cfg_vew_i <= simd_alu_pkg::EW8;
    send_item(64'h8000_7FFF_0001_FFFF, 64'h0001_0001_0001_0001);
    send_item(64'h8000_7FFF_0001_FFFF, 64'h0001_0001_0001_0001);
    drain();
    // Sticky flag cleared, set again by a saturating result, then cleared
    sat_clr_i <= 1'b1;
    next_cycle();
    write_cfg(simd_alu_pkg::OP_SADDU, simd_alu_pkg::EW8);
    send_item('1, '1);
    drain();
    sat_clr_i <= 1'b1;
    next_cycle();
    repeat (4) next_cycle();
    finish_run();
  end

endmodule

`default_nettype wire

// File: simd_alu_checker.sv
// SIMD ALU scoreboard, reference model and output comparisons
`timescale 1ns/1ns
`default_nettype none

`include "simd_alu_consts.svh"

module simd_alu_checker (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cfg_we_i,
  input  simd_alu_pkg::alu_op_e cfg_op_i,
  input  simd_alu_pkg::vew_e    cfg_vew_i,
  input  logic                  sat_clr_i,
  input  logic                  in_valid_i,
  input  simd_alu_pkg::word_t   opa_i,
  input  simd_alu_pkg::word_t   opb_i,
  input  logic                  in_ready_i,
  input  logic                  out_valid_i,
  input  simd_alu_pkg::word_t   result_i,
  input  simd_alu_pkg::sat_t    vxsat_i,
  input  logic                  out_ready_i,
  input  logic                  vxsat_sticky_i,
  output int                    mismatch_cnt_o,
  output int                    fault_cnt_o,
  output int                    pending_o
);

  simd_alu_pkg::result_t exp_q[$];
  simd_alu_pkg::result_t head;
  simd_alu_pkg::alu_op_e op_m;
  simd_alu_pkg::vew_e    vew_m;
  logic                  sticky_m;
  int                    mismatch_cnt = 0;
  int                    fault_cnt = 0;
  int                    pending_cnt = 0;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic simd_alu_pkg::result_t ref_result(
    input simd_alu_pkg::word_t   a,
    input simd_alu_pkg::word_t   b,
    input simd_alu_pkg::alu_op_e op,
    input simd_alu_pkg::vew_e    vew
  );
    simd_alu_pkg::result_t r;
    int                    w;
    logic [64:0]           mask;
    logic [64:0]           la;
    logic [64:0]           lb;
    logic [64:0]           lr;
    logic signed [66:0]    sa;
    logic signed [66:0]    sb;
    logic signed [66:0]    sr;
    logic signed [66:0]    smax;
    logic signed [66:0]    smin;
    logic                  clamp;
    w    = 8 << vew;
    mask = (65'd1 << w) - 65'd1;
    smax = (67'sd1 <<< (w - 1)) - 67'sd1;
    smin = -(67'sd1 <<< (w - 1));
    r    = '0;
    for (int l = 0; l < `SIMD_DATA_W / w; l++) begin
      la = ({1'b0, a} >> (l * w)) & mask;
      lb = ({1'b0, b} >> (l * w)) & mask;
      // Two's complement value of each lane
      sa = $signed({2'b00, la}) - (la[w-1] ? (67'sd1 <<< w) : 67'sd0);
      sb = $signed({2'b00, lb}) - (lb[w-1] ? (67'sd1 <<< w) : 67'sd0);
      clamp = 1'b0;
      case (op)
        simd_alu_pkg::OP_AND: lr = la & lb;
        simd_alu_pkg::OP_OR:  lr = la | lb;
        simd_alu_pkg::OP_XOR: lr = la ^ lb;
        simd_alu_pkg::OP_ADD: lr = (la + lb) & mask;
        simd_alu_pkg::OP_SUB: lr = (lb - la) & mask;
        simd_alu_pkg::OP_SADDU: begin
          lr = la + lb;
          if (lr > mask) begin
            lr    = mask;
            clamp = 1'b1;
          end
        end
        simd_alu_pkg::OP_SSUBU: begin
          lr = (lb < la) ? 65'd0 : lb - la;
          clamp = (lb < la);
        end
        simd_alu_pkg::OP_SADD, simd_alu_pkg::OP_SSUB: begin
          sr = (op == simd_alu_pkg::OP_SADD) ? sa + sb : sb - sa;
          if (sr > smax) begin
            sr    = smax;
            clamp = 1'b1;
          end else if (sr < smin) begin
            sr    = smin;
            clamp = 1'b1;
          end
          lr = sr[64:0] & mask;
        end
        simd_alu_pkg::OP_MINU: lr = (lb < la) ? lb : la;
        simd_alu_pkg::OP_MAXU: lr = (lb > la) ? lb : la;
        simd_alu_pkg::OP_MIN:  lr = (sb < sa) ? lb : la;
        default:               lr = (sb > sa) ? lb : la;
      endcase
      r.res = r.res | (lr[63:0] << (l * w));
      if (clamp) begin
        r.sat = r.sat | (8'((16'd1 << (w / 8)) - 16'd1) << (l * w / 8));
      end
    end
    return r;
  endfunction

  ////////////////////
  // Scoreboard
  ////////////////////

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_q.delete();
      op_m     = simd_alu_pkg::OP_ADD;
      vew_m    = simd_alu_pkg::EW8;
      sticky_m = 1'b0;
    end else begin
      if (vxsat_sticky_i !== sticky_m) begin
        $display("MISMATCH %0t sticky flag got %b exp %b", $time, vxsat_sticky_i, sticky_m);
        mismatch_cnt++;
      end
      if (out_valid_i && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t: output transfer with no accepted input outstanding", $time);
          fault_cnt++;
        end else begin
          head = exp_q.pop_front();
          if (result_i !== head.res || vxsat_i !== head.sat) begin
            $display("MISMATCH %0t result got %h/%h exp %h/%h", $time, result_i, vxsat_i,
                     head.res, head.sat);
            mismatch_cnt++;
          end
          if (head.sat != '0) begin
            sticky_m = 1'b1;
          end else if (sat_clr_i) begin
            sticky_m = 1'b0;
          end
        end
      end else if (sat_clr_i) begin
        sticky_m = 1'b0;
      end
      // Item takes the op and width held before this edge
      if (in_valid_i && in_ready_i) begin
        exp_q.push_back(ref_result(opa_i, opb_i, op_m, vew_m));
      end
      if (cfg_we_i) begin
        op_m  = cfg_op_i;
        vew_m = cfg_vew_i;
      end
    end
    pending_cnt = exp_q.size();
  end

  assign mismatch_cnt_o = mismatch_cnt;
  assign fault_cnt_o    = fault_cnt;
  assign pending_o      = pending_cnt;

endmodule

`default_nettype wire

// File: simd_alu_top.sv
// SIMD ALU top, configuration block and two-stage pipeline around the core
`timescale 1ns/1ns
`default_nettype none

module simd_alu_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cfg_we_i,
  input  simd_alu_pkg::alu_op_e cfg_op_i,
  input  simd_alu_pkg::vew_e    cfg_vew_i,
  input  logic                  sat_clr_i,
  input  logic                  in_valid_i,
  input  simd_alu_pkg::word_t   opa_i,
  input  simd_alu_pkg::word_t   opb_i,
  output logic                  in_ready_o,
  output logic                  out_valid_o,
  output simd_alu_pkg::word_t   result_o,
  output simd_alu_pkg::sat_t    vxsat_o,
  input  logic                  out_ready_i,
  output logic                  vxsat_sticky_o
);

  simd_alu_pkg::alu_op_e op;
  simd_alu_pkg::vew_e    vew;
  simd_alu_pkg::issue_t  issue_d;
  simd_alu_pkg::issue_t  issue_q;
  logic                  issue_valid;
  logic                  issue_ready;
  simd_alu_pkg::result_t result_d;
  simd_alu_pkg::result_t result_q;

  simd_alu_cfg u_cfg (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .cfg_we_i       (cfg_we_i),
    .cfg_op_i       (cfg_op_i),
    .cfg_vew_i      (cfg_vew_i),
    .sat_clr_i      (sat_clr_i),
    .done_i         (out_valid_o & out_ready_i),
    .done_sat_i     (result_q.sat),
    .op_o           (op),
    .vew_o          (vew),
    .vxsat_sticky_o (vxsat_sticky_o)
  );

  // Op and width are frozen with the operands at acceptance
  assign issue_d = '{opa: opa_i, opb: opb_i, op: op, vew: vew};

  pipe_reg #(.payload_t(simd_alu_pkg::issue_t)) u_issue (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (issue_d),
    .in_ready_o  (in_ready_o),
    .out_valid_o (issue_valid),
    .out_data_o  (issue_q),
    .out_ready_i (issue_ready)
  );

  simd_alu_core u_core (
    .issue_i  (issue_q),
    .result_o (result_d)
  );

  pipe_reg #(.payload_t(simd_alu_pkg::result_t)) u_result (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (issue_valid),
    .in_data_i   (result_d),
    .in_ready_o  (issue_ready),
    .out_valid_o (out_valid_o),
    .out_data_o  (result_q),
    .out_ready_i (out_ready_i)
  );

  assign result_o = result_q.res;
  assign vxsat_o  = result_q.sat;

endmodule

`default_nettype wire

// File: simd_alu_core.sv
// Combinational ALU core, bitwise ops and result select
`timescale 1ns/1ns
`default_nettype none

module simd_alu_core (
  input  simd_alu_pkg::issue_t  issue_i,
  output simd_alu_pkg::result_t result_o
);

  simd_alu_pkg::word_t addsub_res;
  simd_alu_pkg::sat_t  addsub_sat;
  simd_alu_pkg::word_t minmax_res;
  simd_alu_pkg::word_t res;

  simd_addsub u_addsub (
    .opa_i (issue_i.opa),
    .opb_i (issue_i.opb),
    .op_i  (issue_i.op),
    .vew_i (issue_i.vew),
    .sum_o (addsub_res),
    .sat_o (addsub_sat)
  );

  simd_minmax u_minmax (
    .opa_i (issue_i.opa),
    .opb_i (issue_i.opb),
    .op_i  (issue_i.op),
    .vew_i (issue_i.vew),
    .sel_o (minmax_res)
  );

  ////////////////////
  // Result select
  ////////////////////

  always_comb begin
    unique case (issue_i.op)
      simd_alu_pkg::OP_AND: res = issue_i.opa & issue_i.opb;
      simd_alu_pkg::OP_OR:  res = issue_i.opa | issue_i.opb;
      simd_alu_pkg::OP_XOR: res = issue_i.opa ^ issue_i.opb;
      simd_alu_pkg::OP_ADD,
      simd_alu_pkg::OP_SUB,
      simd_alu_pkg::OP_SADDU,
      simd_alu_pkg::OP_SADD,
      simd_alu_pkg::OP_SSUBU,
      simd_alu_pkg::OP_SSUB: res = addsub_res;
      default: res = minmax_res;
    endcase
  end

  // Flags are already zero for every non-saturating op
  assign result_o.res = res;
  assign result_o.sat = addsub_sat;

endmodule

`default_nettype wire

// File: simd_minmax.sv
// Lane-wise signed and unsigned minimum/maximum
`timescale 1ns/1ns
`default_nettype none

`include "simd_alu_consts.svh"

module simd_minmax (
  input  simd_alu_pkg::word_t   opa_i,
  input  simd_alu_pkg::word_t   opb_i,
  input  simd_alu_pkg::alu_op_e op_i,
  input  simd_alu_pkg::vew_e    vew_i,
  output simd_alu_pkg::word_t   sel_o
);

  logic [3:0][`SIMD_DATA_W-1:0] sel_w;
  logic                         is_signed;
  logic                         is_max;

  assign is_signed = op_i inside {simd_alu_pkg::OP_MIN, simd_alu_pkg::OP_MAX};
  assign is_max    = op_i inside {simd_alu_pkg::OP_MAX, simd_alu_pkg::OP_MAXU};

  for (genvar g = 0; g < 4; g++) begin : g_width
    localparam int unsigned W = 8 << g;
    localparam int unsigned N = `SIMD_BYTES >> g;

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic         less;

      assign a = opa_i[l*W +: W];
      assign b = opb_i[l*W +: W];

      // Extra top bit carries the sign only for signed ops
      assign less = $signed({is_signed & b[W-1], b}) < $signed({is_signed & a[W-1], a});

      // B when it is the smaller for MIN, A when B is smaller for MAX
      assign sel_w[g][l*W +: W] = (less ^ is_max) ? b : a;
    end
  end

  assign sel_o = sel_w[vew_i];

endmodule

`default_nettype wire

// File: simd_addsub.sv
// Lane-wise wrapping and saturating add/subtract with per-byte flags
`timescale 1ns/1ns
`default_nettype none

`include "simd_alu_consts.svh"

module simd_addsub (
  input  simd_alu_pkg::word_t   opa_i,
  input  simd_alu_pkg::word_t   opb_i,
  input  simd_alu_pkg::alu_op_e op_i,
  input  simd_alu_pkg::vew_e    vew_i,
  output simd_alu_pkg::word_t   sum_o,
  output simd_alu_pkg::sat_t    sat_o
);

  // Candidate results for every lane width, picked by vew afterwards
  logic [3:0][`SIMD_DATA_W-1:0] res_w;
  logic [3:0][`SIMD_BYTES-1:0]  sat_w;
  logic                         is_sub;

  assign is_sub = op_i inside {simd_alu_pkg::OP_SUB, simd_alu_pkg::OP_SSUBU,
                               simd_alu_pkg::OP_SSUB};

  for (genvar g = 0; g < 4; g++) begin : g_width
    localparam int unsigned W = 8 << g;
    localparam int unsigned N = `SIMD_BYTES >> g;

    for (genvar l = 0; l < N; l++) begin : g_lane
      logic [W-1:0] a;
      logic [W-1:0] b;
      logic [W:0]   sum;
      logic [W:0]   dif;
      logic         sadd_ovf;
      logic         ssub_ovf;
      logic         ovf;
      logic [W-1:0] lim;

      assign a   = opa_i[l*W +: W];
      assign b   = opb_i[l*W +: W];
      // Subtract is B minus A
      assign sum = {1'b0, a} + {1'b0, b};
      assign dif = {1'b0, b} - {1'b0, a};

      // Same-sign inputs, result sign flipped
      assign sadd_ovf = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
      // Opposite-sign inputs, result sign differs from B
      assign ssub_ovf = (a[W-1] != b[W-1]) && (dif[W-1] != b[W-1]);

      always_comb begin
        ovf = 1'b0;
        lim = '0;
        unique case (op_i)
          simd_alu_pkg::OP_SADDU: begin
            ovf = sum[W];
            lim = '1;
          end
          simd_alu_pkg::OP_SSUBU: begin
            ovf = dif[W];
            lim = '0;
          end
          simd_alu_pkg::OP_SADD: begin
            ovf = sadd_ovf;
            lim = a[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
          end
          simd_alu_pkg::OP_SSUB: begin
            ovf = ssub_ovf;
            lim = b[W-1] ? {1'b1, {(W-1){1'b0}}} : {1'b0, {(W-1){1'b1}}};
          end
          default: ;
        endcase
      end

      assign res_w[g][l*W +: W] = ovf ? lim : (is_sub ? dif[W-1:0] : sum[W-1:0]);
      assign sat_w[g][l*(W/8) +: W/8] = {(W/8){ovf}};
    end
  end

  assign sum_o = res_w[vew_i];
  assign sat_o = sat_w[vew_i];

endmodule

`default_nettype wire

// File: simd_alu_cfg.sv
// Operation and element width registers, sticky saturation flag
`timescale 1ns/1ns
`default_nettype none

`include "simd_alu_consts.svh"

module simd_alu_cfg (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  cfg_we_i,
  input  simd_alu_pkg::alu_op_e cfg_op_i,
  input  simd_alu_pkg::vew_e    cfg_vew_i,
  input  logic                  sat_clr_i,
  input  logic                  done_i,
  input  simd_alu_pkg::sat_t    done_sat_i,
  output simd_alu_pkg::alu_op_e op_o,
  output simd_alu_pkg::vew_e    vew_o,
  output logic                  vxsat_sticky_o
);

  simd_alu_pkg::alu_op_e op_q;
  simd_alu_pkg::vew_e    vew_q;
  logic                  sticky_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      op_q  <= simd_alu_pkg::OP_ADD;
      vew_q <= simd_alu_pkg::EW8;
    end else if (cfg_we_i) begin
      op_q  <= cfg_op_i;
      vew_q <= cfg_vew_i;
    end
  end

  // Set has priority over a clear on the same edge
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sticky_q <= 1'b0;
    end else if (done_i && (|done_sat_i)) begin
      sticky_q <= 1'b1;
    end else if (sat_clr_i) begin
      sticky_q <= 1'b0;
    end
  end

  assign op_o           = op_q;
  assign vew_o          = vew_q;
  assign vxsat_sticky_o = sticky_q;

  ////////////////////
  // Assertions
  ////////////////////

  a_op_legal : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    cfg_we_i |-> ($unsigned(cfg_op_i) < `SIMD_OP_CNT)
  );

endmodule

`default_nettype wire

// File: pipe_reg.sv
// Single valid/ready register slice with a generic payload
`timescale 1ns/1ns
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     valid_q;
  payload_t data_q;

  // Take a new item when empty or when the held one leaves now
  assign in_ready_o = ~valid_q | out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  ////////////////////
  // Assertions
  ////////////////////

  // Stalled output must not change under the sink
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_data_o))
  );

endmodule

`default_nettype wire

// File: simd_alu_pkg.sv
// Operation, element width and pipeline payload types
`default_nettype none

`include "simd_alu_consts.svh"

package simd_alu_pkg;

  typedef enum logic [`SIMD_OP_W-1:0] {
    OP_AND   = `SIMD_OP_AND,
    OP_OR    = `SIMD_OP_OR,
    OP_XOR   = `SIMD_OP_XOR,
    OP_ADD   = `SIMD_OP_ADD,
    OP_SUB   = `SIMD_OP_SUB,
    OP_SADDU = `SIMD_OP_SADDU,
    OP_SADD  = `SIMD_OP_SADD,
    OP_SSUBU = `SIMD_OP_SSUBU,
    OP_SSUB  = `SIMD_OP_SSUB,
    OP_MINU  = `SIMD_OP_MINU,
    OP_MIN   = `SIMD_OP_MIN,
    OP_MAXU  = `SIMD_OP_MAXU,
    OP_MAX   = `SIMD_OP_MAX
  } alu_op_e;

  // Lane width encoding doubles as log2 of bytes per lane
  typedef enum logic [`SIMD_VEW_W-1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef logic [`SIMD_DATA_W-1:0] word_t;
  // One flag per byte, repeated across a lane
  typedef logic [`SIMD_BYTES-1:0]  sat_t;

  typedef struct packed {
    word_t   opa;
    word_t   opb;
    alu_op_e op;
    vew_e    vew;
  } issue_t;

  typedef struct packed {
    word_t res;
    sat_t  sat;
  } result_t;

endpackage

`default_nettype wire

// File: simd_alu_consts.svh
// Word geometry and operation codes of the SIMD ALU
`ifndef SIMD_ALU_CONSTS_SVH
`define SIMD_ALU_CONSTS_SVH

// Datapath geometry
`define SIMD_DATA_W 64
`define SIMD_BYTES  8
`define SIMD_OP_W   4
`define SIMD_VEW_W  2

// Operation encodings
`define SIMD_OP_AND   4'd0
`define SIMD_OP_OR    4'd1
`define SIMD_OP_XOR   4'd2
`define SIMD_OP_ADD   4'd3
`define SIMD_OP_SUB   4'd4
`define SIMD_OP_SADDU 4'd5
`define SIMD_OP_SADD  4'd6
`define SIMD_OP_SSUBU 4'd7
`define SIMD_OP_SSUB  4'd8
`define SIMD_OP_MINU  4'd9
`define SIMD_OP_MIN   4'd10
`define SIMD_OP_MAXU  4'd11
`define SIMD_OP_MAX   4'd12
`define SIMD_OP_CNT   13

`endif
